//--- vlog.f
hw/lj_pkg.sv
hw/lj_pos_ram.sv
hw/lj_apb_regs.sv
hw/lj_pair_ctrl.sv
hw/lj_r2_compute.sv
hw/lj_force_interp.sv
hw/lj_force_accum.sv
hw/lj_tile_top.sv
test/lj_tile_tb.sv

//--- test/lj_tile_tb.sv
`timescale 1ns/100ps

module lj_tile_tb;

	localparam int CLK_PERIOD = 8;
	localparam int RUN_CYC = lj_pkg::REF_MAX * lj_pkg::NBR_MAX + lj_pkg::PIPE_LAT + 2; // Worst run
	localparam int APB_CYC = 5 * (2 * 3 * (4 + 8) + 2 * 128 + 2 * 3 * 4 + 24); // All transfers
	localparam int WATCHDOG_CYC = 2 * (16 + 2 * RUN_CYC + APB_CYC); // Two runs plus margin

	logic clk, rst, psel, penable, pwrite, pready, pslverr, done;
	logic [12:0] paddr;
	logic [31:0] pwdata, prdata;

	int seed;
	int mismatches = 0;
	int other_errors = 0;
	int ref_pos [lj_pkg::REF_MAX][3]; // Data as written, for the model
	int nbr_pos [lj_pkg::NBR_MAX][3];
	int c0_tbl [2**lj_pkg::TBL_AW];
	int c1_tbl [2**lj_pkg::TBL_AW];
	int done_pulses = 0;
	int run_cycles = 0;
	int run_len = 0;
	logic timing = 1'b0; // Between start and done

	lj_tile_top lj_tile_top_i (.clk(clk), .rst(rst), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .done(done));

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Protocol rules that hold every cycle
	assert property (@(posedge clk) disable iff (rst) !psel |-> !pready && !pslverr)
	else
	begin
		other_errors++;
		$display("pready or pslverr active outside a transfer");
	end
	assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
	else
	begin
		other_errors++;
		$display("pslverr raised without pready");
	end
	assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else
	begin
		other_errors++;
		$display("done held high for more than one cycle");
	end

	// Run length counts the start cycle through the done cycle
	always @(posedge clk)
	begin
		if (rst)
		begin
			timing <= 1'b0;
			done_pulses <= 0;
		end
		else
		begin
			if (psel && penable && pwrite && pready && !pslverr &&
				paddr == lj_pkg::REG_CTRL && pwdata[0])
			begin
				timing <= 1'b1;
				run_cycles <= 1;
			end
			else if (timing)
				run_cycles <= run_cycles + 1;
			if (done)
			begin
				timing <= 1'b0;
				run_len <= run_cycles + 1;
				done_pulses <= done_pulses + 1;
			end
		end
	end

	function automatic logic [12:0] pos_addr(input logic [12:0] base, input int idx,
		input int comp);
		return base + 13'(idx * 16 + comp * 4); // Same layout for positions and forces
	endfunction

	// Sum over kept pairs of the interpolated scale times the delta
	function automatic logic [31:0] model_force(input int r, input int comp, input int n_cnt);
		longint d [3];
		longint r2, slope, scale, sum;
		int n, k, idx, frac;
		sum = 0;
		for (n = 0; n < n_cnt; n++)
		begin
			for (k = 0; k < 3; k++)
				d[k] = nbr_pos[n][k] - ref_pos[r][k];
			r2 = d[0] * d[0] + d[1] * d[1] + d[2] * d[2];
			if (r2 > 0 && r2 < lj_pkg::CUTOFF_2)
			begin
				idx = int'((r2 >> lj_pkg::FRAC_W) % (1 << lj_pkg::TBL_AW));
				frac = int'(r2 % (1 << lj_pkg::FRAC_W));
				slope = longint'(c1_tbl[idx]) * frac;
				scale = c0_tbl[idx] + (slope >>> lj_pkg::FRAC_W);
				scale = (scale << (64 - lj_pkg::SCALE_W)) >>> (64 - lj_pkg::SCALE_W); // 24 bits
				sum += scale * d[comp];
			end
		end
		return sum[31:0]; // Wraps modulo 2**32
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp)
		else
		begin
			mismatches++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic apb_transfer(input logic wr, input logic [12:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err, output int waits);
		@(posedge clk);
		psel <= 1'b1; // Setup phase
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		waits = 0;
		@(negedge clk);
		while (!pready && waits < 4)
		begin
			waits++;
			@(negedge clk);
		end
		assert (pready)
		else
		begin
			other_errors++;
			$display("No pready for access to %h", addr);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0; // Transfer completes on this edge
		penable <= 1'b0;
	endtask

	task automatic write_ok(input logic [12:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		int waits;
		apb_transfer(1'b1, addr, data, rdata, err, waits);
		assert (!err && waits == 0)
		else
		begin
			other_errors++;
			$display("Write to %h gave an error or a wait state", addr);
		end
	endtask

	task automatic read_check(input string name, input logic [12:0] addr,
		input logic [31:0] exp, input int exp_waits);
		logic [31:0] rdata;
		logic err;
		int waits;
		apb_transfer(1'b0, addr, 32'd0, rdata, err, waits);
		assert (!err && waits == exp_waits)
		else
		begin
			other_errors++;
			$display("Read of %h gave an error or %0d wait states", addr, waits);
		end
		check_value(name, exp, rdata);
	endtask

	task automatic load_positions(input int r_cnt, input int n_cnt);
		for (int i = 0; i < r_cnt; i++)
			for (int k = 0; k < 3; k++)
				write_ok(pos_addr(lj_pkg::BASE_REF, i, k), ref_pos[i][k]);
		for (int i = 0; i < n_cnt; i++)
			for (int k = 0; k < 3; k++)
				write_ok(pos_addr(lj_pkg::BASE_NBR, i, k), nbr_pos[i][k]);
	endtask

	task automatic load_table();
		logic signed [15:0] tmp;
		for (int i = 0; i < 2**lj_pkg::TBL_AW; i++)
		begin
			tmp = 16'($random(seed));
			c0_tbl[i] = tmp;
			tmp = 16'($random(seed));
			c1_tbl[i] = tmp;
			write_ok(lj_pkg::BASE_TBL + 13'(i * 8), c0_tbl[i]); // Offset 0 is c0
			write_ok(lj_pkg::BASE_TBL + 13'(i * 8 + 4), c1_tbl[i]);
		end
	endtask

	task automatic wait_done(input int prev);
		int cycles;
		cycles = 0;
		while (done_pulses == prev && cycles < RUN_CYC + 16)
		begin
			@(negedge clk);
			cycles++;
		end
		assert (done_pulses != prev)
		else
		begin
			other_errors++;
			$display("Run did not signal done within %0d cycles", cycles);
		end
	endtask

	task automatic check_forces(input string name, input int r_cnt, input int n_cnt);
		for (int r = 0; r < r_cnt; r++)
			for (int k = 0; k < 3; k++)
				read_check($sformatf("%s_ref%0d_c%0d", name, r, k),
					pos_addr(lj_pkg::BASE_FORCE, r, k), model_force(r, k, n_cnt), 1);
	endtask

	initial
	begin
		logic [31:0] rdata;
		logic err;
		int waits;
		logic [31:0] kept_force [3];
		seed = 23;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (4)
		begin
			@(negedge clk);
			assert (!done && !pready && !pslverr)
			else
			begin
				other_errors++;
				$display("Output active after reset before any access");
			end
		end
		read_check("status_reset", lj_pkg::REG_STATUS, 32'd0, 0);
		for (int i = 0; i < 4; i++)
			for (int k = 0; k < 3; k++)
				ref_pos[i][k] = $random(seed) % 48;
		for (int i = 0; i < 8; i++)
			for (int k = 0; k < 3; k++)
				nbr_pos[i][k] = $random(seed) % 48;
		for (int k = 0; k < 3; k++)
		begin
			nbr_pos[0][k] = ref_pos[0][k]; // Self pair with reference 0
			nbr_pos[6][k] = ref_pos[1][k];
			ref_pos[3][k] = 1000; // Out of range of every neighbor
		end
		nbr_pos[6][0] = ref_pos[1][0] + 128; // Exactly at the cutoff
		nbr_pos[7][0] = -2000;
		load_positions(4, 8);
		load_table();
		write_ok(lj_pkg::REG_COUNT, {18'd0, 6'd7, 8'd3}); // 8 neighbors, 4 references
		write_ok(lj_pkg::REG_CTRL, 32'd1);
		// Locked out while the run is busy
		apb_transfer(1'b1, pos_addr(lj_pkg::BASE_NBR, 2, 0), 32'h1234, rdata, err, waits);
		assert (err)
		else
		begin
			other_errors++;
			$display("Position write while busy was not rejected");
		end
		apb_transfer(1'b0, pos_addr(lj_pkg::BASE_FORCE, 0, 0), 32'd0, rdata, err, waits);
		assert (err)
		else
		begin
			other_errors++;
			$display("Force read while busy was not rejected");
		end
		read_check("status_busy", lj_pkg::REG_STATUS, 32'd1, 0);
		wait_done(0);
		check_value("run_length_1", 4 * 8 + lj_pkg::PIPE_LAT + 2, run_len);
		read_check("status_done", lj_pkg::REG_STATUS, 32'd2, 0);
		check_forces("run1", 4, 8);
		for (int k = 0; k < 3; k++)
			read_check($sformatf("all_rejected_c%0d", k), pos_addr(lj_pkg::BASE_FORCE, 3, k),
				32'd0, 1);
		read_check("status_sticky", lj_pkg::REG_STATUS, 32'd2, 0);
		check_value("done_pulses_1", 1, done_pulses);
		for (int k = 0; k < 3; k++)
			kept_force[k] = model_force(2, k, 8); // Ref 2 is left out of the second run
		// Second run, fewer pairs and a fresh table
		load_table();
		write_ok(lj_pkg::REG_COUNT, {18'd0, 6'd4, 8'd1}); // 5 neighbors, 2 references
		write_ok(lj_pkg::REG_CTRL, 32'd1);
		read_check("status_restart", lj_pkg::REG_STATUS, 32'd1, 0);
		wait_done(1);
		check_value("run_length_2", 2 * 5 + lj_pkg::PIPE_LAT + 2, run_len);
		check_value("done_pulses_2", 2, done_pulses);
		check_forces("run2", 2, 5);
		for (int k = 0; k < 3; k++)
			read_check($sformatf("kept_ref2_c%0d", k), pos_addr(lj_pkg::BASE_FORCE, 2, k),
				kept_force[k], 1); // Not covered, keeps the first result
		repeat (2) @(posedge clk);
		$display("Mismatches: %0d, other errors: %0d", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYC);
		$display("Mismatches: %0d, other errors: %0d", mismatches, other_errors);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- hw/lj_tile_top.sv
`timescale 1ns/100ps

module lj_tile_top
(
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [12:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic done
);

	// Host side
	logic busy, start;
	logic [lj_pkg::REF_AW-1:0] ref_cnt, ref_idx, pair_ref, r2_ref, f_ref, force_rd_idx;
	logic [lj_pkg::NBR_AW-1:0] nbr_cnt, nbr_idx;
	logic ram_we_ref, ram_we_nbr, tbl_we_c0, tbl_we_c1;
	logic [lj_pkg::TBL_AW-1:0] wr_idx;
	logic [1:0] wr_comp, force_rd_comp;
	logic [lj_pkg::COORD_W-1:0] wr_data;
	logic force_rd_en;
	logic [lj_pkg::FORCE_W-1:0] force_rd_data;
	// Pair pipeline
	logic pair_valid, pair_last, r2_keep, r2_last, r2_valid, f_last, f_valid;
	logic signed [lj_pkg::COORD_W-1:0] ref_x, ref_y, ref_z, nbr_x, nbr_y, nbr_z;
	logic signed [lj_pkg::DELTA_W-1:0] dx, dy, dz;
	logic [lj_pkg::R2_W-1:0] r2;
	logic signed [lj_pkg::FORCE_W-1:0] fx, fy, fz;

	lj_apb_regs regs_i (.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .start(start), .ref_cnt(ref_cnt), .nbr_cnt(nbr_cnt),
		.ram_we_ref(ram_we_ref), .ram_we_nbr(ram_we_nbr), .tbl_we_c0(tbl_we_c0),
		.tbl_we_c1(tbl_we_c1), .wr_idx(wr_idx), .wr_comp(wr_comp), .wr_data(wr_data),
		.force_rd_en(force_rd_en), .force_rd_idx(force_rd_idx), .force_rd_comp(force_rd_comp),
		.force_rd_data(force_rd_data), .run_done(done));

	// Both memories are read for the whole run
	lj_pos_ram #(.DEPTH(lj_pkg::REF_MAX)) ref_ram (.clk(clk), .we(ram_we_ref),
		.wr_idx(wr_idx[lj_pkg::REF_AW-1:0]), .wr_comp(wr_comp), .wr_data(wr_data),
		.rd_en(busy), .rd_idx(ref_idx), .x(ref_x), .y(ref_y), .z(ref_z));

	lj_pos_ram #(.DEPTH(lj_pkg::NBR_MAX)) nbr_ram (.clk(clk), .we(ram_we_nbr),
		.wr_idx(wr_idx[lj_pkg::NBR_AW-1:0]), .wr_comp(wr_comp), .wr_data(wr_data),
		.rd_en(busy), .rd_idx(nbr_idx), .x(nbr_x), .y(nbr_y), .z(nbr_z));

	lj_pair_ctrl ctrl_i (.clk(clk), .rst(rst), .start(start), .ref_cnt(ref_cnt),
		.nbr_cnt(nbr_cnt), .ref_idx(ref_idx), .nbr_idx(nbr_idx), .pair_valid(pair_valid),
		.pair_ref(pair_ref), .pair_last(pair_last), .busy(busy), .done(done));

	lj_r2_compute r2_i (.clk(clk), .rst(rst), .in_valid(pair_valid), .in_ref(pair_ref),
		.in_last(pair_last), .ref_x(ref_x), .ref_y(ref_y), .ref_z(ref_z), .nbr_x(nbr_x),
		.nbr_y(nbr_y), .nbr_z(nbr_z), .dx(dx), .dy(dy), .dz(dz), .r2(r2), .keep(r2_keep),
		.out_ref(r2_ref), .out_last(r2_last), .out_valid(r2_valid));

	lj_force_interp interp_i (.clk(clk), .rst(rst), .tbl_we_c0(tbl_we_c0),
		.tbl_we_c1(tbl_we_c1), .wr_idx(wr_idx), .wr_data(wr_data), .dx(dx), .dy(dy), .dz(dz),
		.r2(r2), .keep(r2_keep), .in_ref(r2_ref), .in_last(r2_last), .in_valid(r2_valid),
		.fx(fx), .fy(fy), .fz(fz), .out_ref(f_ref), .out_last(f_last), .out_valid(f_valid));

	lj_force_accum accum_i (.clk(clk), .rst(rst), .start(start), .in_valid(f_valid),
		.in_ref(f_ref), .in_last(f_last), .fx(fx), .fy(fy), .fz(fz), .rd_en(force_rd_en),
		.rd_idx(force_rd_idx), .rd_comp(force_rd_comp), .rd_data(force_rd_data));

endmodule

//--- hw/lj_force_accum.sv
`timescale 1ns/100ps

module lj_force_accum
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic in_valid,
	input  logic [lj_pkg::REF_AW-1:0] in_ref,
	input  logic in_last,
	input  logic signed [lj_pkg::FORCE_W-1:0] fx,
	input  logic signed [lj_pkg::FORCE_W-1:0] fy,
	input  logic signed [lj_pkg::FORCE_W-1:0] fz,
	input  logic rd_en,
	input  logic [lj_pkg::REF_AW-1:0] rd_idx,
	input  logic [1:0] rd_comp,
	output logic [lj_pkg::FORCE_W-1:0] rd_data
);

	logic signed [lj_pkg::FORCE_W-1:0] sum_x, sum_y, sum_z;
	logic signed [lj_pkg::FORCE_W-1:0] next_x, next_y, next_z;
	logic [lj_pkg::FORCE_W-1:0] mem_x [lj_pkg::REF_MAX]; // Result per reference
	logic [lj_pkg::FORCE_W-1:0] mem_y [lj_pkg::REF_MAX];
	logic [lj_pkg::FORCE_W-1:0] mem_z [lj_pkg::REF_MAX];

	// Running sum including this cycle's contribution, wraps at 32 bits
	assign next_x = sum_x + fx;
	assign next_y = sum_y + fy;
	assign next_z = sum_z + fz;

	always_ff @(posedge clk)
	begin
		if (rst || start)
		begin
			sum_x <= '0;
			sum_y <= '0;
			sum_z <= '0;
		end
		else if (in_valid)
		begin
			sum_x <= in_last ? '0 : next_x; // Restart for the next reference
			sum_y <= in_last ? '0 : next_y;
			sum_z <= in_last ? '0 : next_z;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_last)
		begin
			mem_x[in_ref] <= next_x;
			mem_y[in_ref] <= next_y;
			mem_z[in_ref] <= next_z;
		end
		if (rd_en)
			case (rd_comp)
				2'd0: rd_data <= mem_x[rd_idx];
				2'd1: rd_data <= mem_y[rd_idx];
				2'd2: rd_data <= mem_z[rd_idx];
				default: rd_data <= '0;
			endcase
	end

endmodule

//--- hw/lj_force_interp.sv
`timescale 1ns/100ps

module lj_force_interp
(
	input  logic clk,
	input  logic rst,
	input  logic tbl_we_c0,
	input  logic tbl_we_c1,
	input  logic [lj_pkg::TBL_AW-1:0] wr_idx,
	input  logic signed [lj_pkg::COEF_W-1:0] wr_data,
	input  logic signed [lj_pkg::DELTA_W-1:0] dx,
	input  logic signed [lj_pkg::DELTA_W-1:0] dy,
	input  logic signed [lj_pkg::DELTA_W-1:0] dz,
	input  logic [lj_pkg::R2_W-1:0] r2,
	input  logic keep,
	input  logic [lj_pkg::REF_AW-1:0] in_ref,
	input  logic in_last,
	input  logic in_valid,
	output logic signed [lj_pkg::FORCE_W-1:0] fx,
	output logic signed [lj_pkg::FORCE_W-1:0] fy,
	output logic signed [lj_pkg::FORCE_W-1:0] fz,
	output logic [lj_pkg::REF_AW-1:0] out_ref,
	output logic out_last,
	output logic out_valid
);

	// Offset and slope per segment of r2
	logic signed [lj_pkg::COEF_W-1:0] c0_tbl [2**lj_pkg::TBL_AW];
	logic signed [lj_pkg::COEF_W-1:0] c1_tbl [2**lj_pkg::TBL_AW];

	logic signed [lj_pkg::COEF_W-1:0] c0_s1, c1_s1;
	logic [lj_pkg::FRAC_W-1:0] frac_s1;
	logic signed [lj_pkg::COEF_W+lj_pkg::FRAC_W:0] slope; // c1 times the fraction
	logic signed [lj_pkg::SCALE_W-1:0] scale_s2;
	logic signed [lj_pkg::DELTA_W-1:0] dx_s1, dy_s1, dz_s1, dx_s2, dy_s2, dz_s2;
	logic signed [lj_pkg::SCALE_W+lj_pkg::DELTA_W-1:0] px, py, pz;
	logic [lj_pkg::REF_AW-1:0] ref_s1, ref_s2;
	logic keep_s1, keep_s2, last_s1, last_s2;
	logic valid_s1, valid_s2;

	assign slope = c1_s1 * $signed({1'b0, frac_s1});
	assign px = scale_s2 * dx_s2; // Full width products
	assign py = scale_s2 * dy_s2;
	assign pz = scale_s2 * dz_s2;

	always_ff @(posedge clk)
	begin
		if (tbl_we_c0)
			c0_tbl[wr_idx] <= wr_data;
		if (tbl_we_c1)
			c1_tbl[wr_idx] <= wr_data;
		// Stage one, lookup by the integer part of r2
		c0_s1 <= c0_tbl[r2[lj_pkg::FRAC_W +: lj_pkg::TBL_AW]];
		c1_s1 <= c1_tbl[r2[lj_pkg::FRAC_W +: lj_pkg::TBL_AW]];
		frac_s1 <= r2[lj_pkg::FRAC_W-1:0];
		{dx_s1, dy_s1, dz_s1} <= {dx, dy, dz};
		{ref_s1, keep_s1, last_s1} <= {in_ref, keep, in_last};
		// Stage two, scale = c0 + (c1 * frac) >>> FRAC_W
		scale_s2 <= lj_pkg::SCALE_W'(c0_s1) + lj_pkg::SCALE_W'(slope >>> lj_pkg::FRAC_W);
		{dx_s2, dy_s2, dz_s2} <= {dx_s1, dy_s1, dz_s1};
		{ref_s2, keep_s2, last_s2} <= {ref_s1, keep_s1, last_s1};
		// Stage three, scaled delta or nothing for a rejected pair
		fx <= keep_s2 ? px[lj_pkg::FORCE_W-1:0] : '0;
		fy <= keep_s2 ? py[lj_pkg::FORCE_W-1:0] : '0;
		fz <= keep_s2 ? pz[lj_pkg::FORCE_W-1:0] : '0;
		out_ref <= ref_s2;
		out_last <= last_s2; // Still needed to close the reference sum
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_s1 <= 1'b0;
			valid_s2 <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			valid_s1 <= in_valid;
			valid_s2 <= valid_s1;
			out_valid <= valid_s2;
		end
	end

endmodule

//--- hw/lj_r2_compute.sv
`timescale 1ns/100ps

module lj_r2_compute
(
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic [lj_pkg::REF_AW-1:0] in_ref,
	input  logic in_last,
	input  logic signed [lj_pkg::COORD_W-1:0] ref_x,
	input  logic signed [lj_pkg::COORD_W-1:0] ref_y,
	input  logic signed [lj_pkg::COORD_W-1:0] ref_z,
	input  logic signed [lj_pkg::COORD_W-1:0] nbr_x,
	input  logic signed [lj_pkg::COORD_W-1:0] nbr_y,
	input  logic signed [lj_pkg::COORD_W-1:0] nbr_z,
	output logic signed [lj_pkg::DELTA_W-1:0] dx,
	output logic signed [lj_pkg::DELTA_W-1:0] dy,
	output logic signed [lj_pkg::DELTA_W-1:0] dz,
	output logic [lj_pkg::R2_W-1:0] r2,
	output logic keep,
	output logic [lj_pkg::REF_AW-1:0] out_ref,
	output logic out_last,
	output logic out_valid
);

	logic signed [lj_pkg::DELTA_W-1:0] dx_s1, dy_s1, dz_s1;
	logic signed [2*lj_pkg::DELTA_W-1:0] sq_x, sq_y, sq_z; // Squares are never negative
	logic [lj_pkg::R2_W-1:0] r2_next;
	logic [lj_pkg::REF_AW-1:0] ref_s1;
	logic last_s1;
	logic valid_s1;

	assign sq_x = dx_s1 * dx_s1;
	assign sq_y = dy_s1 * dy_s1;
	assign sq_z = dz_s1 * dz_s1;
	assign r2_next = {1'b0, sq_x} + {1'b0, sq_y} + {1'b0, sq_z};

	always_ff @(posedge clk)
	begin
		// Stage one, sign extended differences
		dx_s1 <= $signed({nbr_x[lj_pkg::COORD_W-1], nbr_x}) - $signed({ref_x[lj_pkg::COORD_W-1], ref_x});
		dy_s1 <= $signed({nbr_y[lj_pkg::COORD_W-1], nbr_y}) - $signed({ref_y[lj_pkg::COORD_W-1], ref_y});
		dz_s1 <= $signed({nbr_z[lj_pkg::COORD_W-1], nbr_z}) - $signed({ref_z[lj_pkg::COORD_W-1], ref_z});
		ref_s1 <= in_ref;
		last_s1 <= in_last;
		// Stage two, distance and filter
		dx <= dx_s1;
		dy <= dy_s1;
		dz <= dz_s1;
		r2 <= r2_next;
		keep <= (r2_next != '0) && (r2_next < lj_pkg::CUTOFF_2); // Drops self pairs too
		out_ref <= ref_s1;
		out_last <= last_s1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_s1 <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			valid_s1 <= in_valid;
			out_valid <= valid_s1;
		end
	end

endmodule

//--- hw/lj_pair_ctrl.sv
`timescale 1ns/100ps

module lj_pair_ctrl
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic [lj_pkg::REF_AW-1:0] ref_cnt,
	input  logic [lj_pkg::NBR_AW-1:0] nbr_cnt,
	output logic [lj_pkg::REF_AW-1:0] ref_idx,
	output logic [lj_pkg::NBR_AW-1:0] nbr_idx,
	output logic pair_valid,
	output logic [lj_pkg::REF_AW-1:0] pair_ref,
	output logic pair_last,
	output logic busy,
	output logic done
);

	lj_pkg::pair_state_e state;
	logic [$clog2(lj_pkg::PIPE_LAT)-1:0] drain_cnt;
	logic nbr_end; // Final neighbor of the current reference

	assign nbr_end = (nbr_idx == nbr_cnt);
	assign busy = (state != lj_pkg::IDLE);
	assign done = (state == lj_pkg::FINISH); // Single cycle

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= lj_pkg::IDLE;
			ref_idx <= '0;
			nbr_idx <= '0;
			drain_cnt <= '0;
			pair_valid <= 1'b0;
			pair_last <= 1'b0;
		end
		else
		begin
			// Tags line up with the memory read data
			pair_valid <= (state == lj_pkg::RUN);
			pair_last <= (state == lj_pkg::RUN) && nbr_end;
			case (state)
				lj_pkg::IDLE:
					if (start)
					begin
						ref_idx <= '0;
						nbr_idx <= '0;
						state <= lj_pkg::RUN;
					end
				lj_pkg::RUN: // One pair per cycle, neighbor loop innermost
					if (nbr_end)
					begin
						nbr_idx <= '0;
						if (ref_idx == ref_cnt)
						begin
							drain_cnt <= '0;
							state <= lj_pkg::DRAIN;
						end
						else
							ref_idx <= ref_idx + 1'b1;
					end
					else
						nbr_idx <= nbr_idx + 1'b1;
				lj_pkg::DRAIN: // Let the last pair reach the accumulator
					if (drain_cnt == lj_pkg::PIPE_LAT - 1)
						state <= lj_pkg::FINISH;
					else
						drain_cnt <= drain_cnt + 1'b1;
				default:
					state <= lj_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
		pair_ref <= ref_idx;

endmodule

//--- hw/lj_apb_regs.sv
`timescale 1ns/100ps

module lj_apb_regs
(
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [12:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic busy,
	output logic start,
	output logic [lj_pkg::REF_AW-1:0] ref_cnt,
	output logic [lj_pkg::NBR_AW-1:0] nbr_cnt,
	output logic ram_we_ref,
	output logic ram_we_nbr,
	output logic tbl_we_c0,
	output logic tbl_we_c1,
	output logic [lj_pkg::TBL_AW-1:0] wr_idx,
	output logic [1:0] wr_comp,
	output logic [lj_pkg::COORD_W-1:0] wr_data,
	output logic force_rd_en,
	output logic [lj_pkg::REF_AW-1:0] force_rd_idx,
	output logic [1:0] force_rd_comp,
	input  logic [lj_pkg::FORCE_W-1:0] force_rd_data,
	input  logic run_done
);

	lj_pkg::region_e region;
	logic access; // Access phase of a transfer
	logic wr_ok; // Write that is not locked out
	logic lock_err;
	logic rd_wait; // Force memory read in flight
	logic done_flag; // Sticky, cleared by start

	// Region decode, component 3 of a position entry is unmapped
	always_comb
	begin
		region = lj_pkg::NONE;
		if (paddr == lj_pkg::REG_CTRL)
			region = lj_pkg::CTRL;
		else if (paddr == lj_pkg::REG_STATUS)
			region = lj_pkg::STATUS;
		else if (paddr == lj_pkg::REG_COUNT)
			region = lj_pkg::COUNT;
		else if (paddr[12:8] == lj_pkg::BASE_REF[12:8] && paddr[3:2] != 2'd3)
			region = lj_pkg::REF; // 16 entries of 16 bytes
		else if (paddr[12:9] == lj_pkg::BASE_NBR[12:9] && paddr[3:2] != 2'd3)
			region = lj_pkg::NBR; // 32 entries
		else if (paddr[12:9] == lj_pkg::BASE_TBL[12:9])
			region = lj_pkg::TBL; // 64 entries of 8 bytes
		else if (paddr[12:8] == lj_pkg::BASE_FORCE[12:8] && paddr[3:2] != 2'd3)
			region = lj_pkg::FORCE;
	end

	assign access = psel & penable;
	assign wr_ok = access & pwrite & ~busy;

	// Loaded data and counts must not change under a running pipeline
	assign lock_err = busy & (pwrite ?
		(region inside {lj_pkg::REF, lj_pkg::NBR, lj_pkg::TBL, lj_pkg::COUNT}) :
		(region == lj_pkg::FORCE));

	assign start = wr_ok & (region == lj_pkg::CTRL) & pwdata[0];
	assign ram_we_ref = wr_ok & (region == lj_pkg::REF);
	assign ram_we_nbr = wr_ok & (region == lj_pkg::NBR);
	assign tbl_we_c0 = wr_ok & (region == lj_pkg::TBL) & ~paddr[2];
	assign tbl_we_c1 = wr_ok & (region == lj_pkg::TBL) & paddr[2];

	// Table index is address / 8, position index is address / 16
	assign wr_idx = (region == lj_pkg::TBL) ? paddr[8:3] : {1'b0, paddr[8:4]};
	assign wr_comp = paddr[3:2]; // x, y, z
	assign wr_data = pwdata[lj_pkg::COORD_W-1:0];

	// First access cycle of a force read launches the memory read
	assign force_rd_en = access & ~pwrite & (region == lj_pkg::FORCE) & ~busy & ~rd_wait;
	assign force_rd_idx = paddr[7:4];
	assign force_rd_comp = paddr[3:2];

	assign pready = access & ~force_rd_en; // One wait state on force reads only
	assign pslverr = access & lock_err;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_wait <= 1'b0;
			done_flag <= 1'b0;
			ref_cnt <= '0;
			nbr_cnt <= '0;
		end
		else
		begin
			rd_wait <= force_rd_en;
			if (start)
				done_flag <= 1'b0;
			else if (run_done)
				done_flag <= 1'b1;
			if (wr_ok && region == lj_pkg::COUNT)
			begin
				ref_cnt <= pwdata[3:0]; // Count minus 1
				nbr_cnt <= pwdata[12:8];
			end
		end
	end

	// Read mux, position and table regions are write only
	always_comb
	begin
		case (region)
			lj_pkg::STATUS: prdata = {30'd0, done_flag, busy};
			lj_pkg::COUNT: prdata = {19'd0, nbr_cnt, 4'd0, ref_cnt};
			lj_pkg::FORCE: prdata = rd_wait ? force_rd_data : 32'd0;
			default: prdata = 32'd0;
		endcase
	end

endmodule

//--- hw/lj_pos_ram.sv
`timescale 1ns/100ps

module lj_pos_ram
#(
	parameter int DEPTH = 16
)
(
	input  logic clk,
	input  logic we,
	input  logic [$clog2(DEPTH)-1:0] wr_idx,
	input  logic [1:0] wr_comp,
	input  logic signed [lj_pkg::COORD_W-1:0] wr_data,
	input  logic rd_en,
	input  logic [$clog2(DEPTH)-1:0] rd_idx,
	output logic signed [lj_pkg::COORD_W-1:0] x,
	output logic signed [lj_pkg::COORD_W-1:0] y,
	output logic signed [lj_pkg::COORD_W-1:0] z
);

	// One array per coordinate so a read returns all three
	logic signed [lj_pkg::COORD_W-1:0] mem_x [DEPTH];
	logic signed [lj_pkg::COORD_W-1:0] mem_y [DEPTH];
	logic signed [lj_pkg::COORD_W-1:0] mem_z [DEPTH];

	always_ff @(posedge clk)
	begin
		if (we && wr_comp == 2'd0)
			mem_x[wr_idx] <= wr_data;
		if (we && wr_comp == 2'd1)
			mem_y[wr_idx] <= wr_data;
		if (we && wr_comp == 2'd2)
			mem_z[wr_idx] <= wr_data;
		if (rd_en)
		begin
			x <= mem_x[rd_idx]; // Data one cycle after the address
			y <= mem_y[rd_idx];
			z <= mem_z[rd_idx];
		end
	end

endmodule

//--- hw/lj_pkg.sv
package lj_pkg;

	// Particle data
	localparam int COORD_W = 16; // Signed position coordinate
	localparam int DELTA_W = 17; // Neighbor minus reference
	localparam int R2_W = 35; // Sum of three squared deltas

	localparam int REF_MAX = 16;
	localparam int REF_AW = 4;
	localparam int NBR_MAX = 32;
	localparam int NBR_AW = 5;

	// Pair is kept for 0 < r2 < CUTOFF_2
	localparam int CUTOFF_2 = 16384;

	// Interpolation table, upper r2 bits pick the entry
	localparam int TBL_AW = 6;
	localparam int FRAC_W = 8; // Low r2 bits used as the fraction
	localparam int COEF_W = 16;
	localparam int SCALE_W = 24;
	localparam int FORCE_W = 32; // Wraps modulo 2**32

	localparam int PIPE_LAT = 6; // Pair issue to accumulation

	// APB address map, 13-bit byte address
	localparam logic [12:0] REG_CTRL = 13'h000;
	localparam logic [12:0] REG_STATUS = 13'h004;
	localparam logic [12:0] REG_COUNT = 13'h008;
	localparam logic [12:0] BASE_REF = 13'h400;
	localparam logic [12:0] BASE_NBR = 13'h800;
	localparam logic [12:0] BASE_TBL = 13'hC00;
	localparam logic [12:0] BASE_FORCE = 13'h1000;

	// Decoded target of an APB access
	typedef enum logic [2:0] {CTRL, STATUS, COUNT, REF, NBR, TBL, FORCE, NONE} region_e;

	typedef enum logic [1:0] {IDLE, RUN, DRAIN, FINISH} pair_state_e;

endpackage
